// ==== list.f ====
+incdir+verif
design/tracelog_pkg.sv
design/trace_if.sv
design/trace_capture.sv
design/trace_record_builder.sv
design/trace_out_port.sv
design/tracelog_top.sv
verif/tracelog_tb.sv

// ==== Bender.yml ====
package:
  name: tracelog

sources:
  - files:
      - design/tracelog_pkg.sv
      - design/trace_if.sv
      - design/trace_capture.sv
      - design/trace_record_builder.sv
      - design/trace_out_port.sv
      - design/tracelog_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tracelog_tb.sv

// ==== verif/tracelog_model.svh ====
//----------------------------------------------------------
// Expected-record model, included inside the testbench module
// Needs tracelog_pkg imported by the including module
//----------------------------------------------------------

`ifndef TRACELOG_MODEL_SVH
`define TRACELOG_MODEL_SVH

// One core update as it sits on the DUT inputs
typedef struct packed {
    logic                  update_pc;
    logic [XLEN-1:0]       npc;
    logic [ILEN-1:0]       instr;
    logic                  reg_we;
    logic [REG_AWIDTH-1:0] reg_addr;
    logic [XLEN-1:0]       reg_data;
    logic                  exc;
    logic                  irq;
    logic                  wake;
    logic [1:0]            st_bits;   // MPIE, MIE
    logic [2:0]            ie_bits;   // MEIE, MTIE, MSIE
    logic [2:0]            ip_bits;   // MEIP, MTIP, MSIP
    logic [XLEN-1:1]       mepc;
    logic                  mcause_irq;
    logic [EC_WIDTH-1:0]   mcause_ec;
    logic [XLEN-1:0]       mtval;
} upd_t;

trace_rec_t      exp_q[$];
logic [XLEN-1:0] model_pc = '0;       // PC chain starts at zero after reset

// Software, timer and external bits sit at 3, 7 and 11
function automatic logic [XLEN-1:0] irq_word(input logic [2:0] bits);
    logic [XLEN-1:0] w;
    w     = '0;
    w[3]  = bits[0];
    w[7]  = bits[1];
    w[11] = bits[2];
    return w;
endfunction

function automatic void push_expected(input trace_rec_t base, input trace_kind_e kind,
                                      input logic [XLEN-1:0] value);
    trace_rec_t r;
    r       = base;
    r.kind  = kind;
    r.value = value;
    exp_q.push_back(r);
endfunction

// Expands one accepted update into its expected records
function automatic void model_expand(input upd_t u);
    trace_rec_t      base;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    base = '0;
    if (u.exc)       base.ev = EV_EXC;
    else if (u.irq)  base.ev = EV_IRQ;
    else if (u.wake) base.ev = EV_WAKE;
    else             base.ev = EV_NONE;
    base.pc    = model_pc;
    base.instr = u.instr;
    base.npc   = u.npc;
    model_pc   = u.npc;
    mstatus        = '0;
    mstatus[3]     = u.st_bits[0];
    mstatus[7]     = u.st_bits[1];
    mstatus[12:11] = 2'b11;           // Machine mode only
    mie = irq_word(u.ie_bits);
    mip = irq_word(u.ip_bits);
    case (base.ev)
        EV_EXC, EV_IRQ: begin
            push_expected(base, REC_MSTATUS, mstatus);
            push_expected(base, REC_MEPC, {u.mepc, 1'b0});
            push_expected(base, REC_MCAUSE,
                          {u.mcause_irq, {(XLEN-EC_WIDTH-1){1'b0}}, u.mcause_ec});
            push_expected(base, REC_MTVAL, u.mtval);
        end
        EV_WAKE: begin
            if ((mip & mie) != '0) begin
                push_expected(base, REC_MIP, mip);
                push_expected(base, REC_MIE, mie);
            end else begin
                push_expected(base, REC_NONE, '0);
            end
        end
        default: begin
            if (u.reg_we && u.reg_addr != '0) begin
                base.reg_addr = u.reg_addr;
                push_expected(base, REC_REG, u.reg_data);
            end else begin
                push_expected(base, REC_NONE, '0);   // No write, or x0
            end
        end
    endcase
endfunction

`endif

// ==== verif/tracelog_tb.sv ====
//----------------------------------------------------------
// Testbench for tracelog_top with random core updates
// Fixed seed, collector acks after 0 to 5 cycles
//----------------------------------------------------------

`timescale 1ns/1ps

module tracelog_tb
    import tracelog_pkg::*;
();

    `include "tracelog_model.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int SEED         = 32'h2d4c5a40;
    localparam int N_REG        = 20;
    localparam int N_PLAIN      = 12;
    localparam int N_TRAP       = 16;
    localparam int N_WAKE       = 16;
    localparam int N_MIX        = 60;
    localparam int N_TOTAL      = N_REG + N_PLAIN + N_TRAP + N_WAKE + N_MIX;
    localparam int DRAIN_CYCLES = 400;
    localparam int MODE_REG     = 0;
    localparam int MODE_PLAIN   = 1;
    localparam int MODE_TRAP    = 2;
    localparam int MODE_WAKE    = 3;
    localparam int MODE_MIX     = 4;

    logic                  clk;
    logic                  rst_n;
    upd_t                  cur;          // Drives all core inputs
    logic                  ready;
    logic                  rec_req;
    trace_event_e          rec_event;
    trace_kind_e           rec_kind;
    logic [XLEN-1:0]       rec_pc;
    logic [ILEN-1:0]       rec_instr;
    logic [XLEN-1:0]       rec_npc;
    logic [REG_AWIDTH-1:0] rec_reg;
    logic [XLEN-1:0]       rec_value;
    logic                  rec_ack;

    int seed      = SEED;
    int ack_seed  = SEED + 1;            // Collector has its own stream
    int ack_min   = 0;
    int err_cnt   = 0;
    int test_pass = 0;
    int test_fail = 0;
    int stall_cnt = 0;

    tracelog_top #(
        .FIFO_DEPTH (4)
    ) u_tracelog_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .update_pc_i    (cur.update_pc),
        .npc_i          (cur.npc),
        .instr_i        (cur.instr),
        .reg_we_i       (cur.reg_we),
        .reg_addr_i     (cur.reg_addr),
        .reg_data_i     (cur.reg_data),
        .e_exc_i        (cur.exc),
        .e_irq_i        (cur.irq),
        .e_wake_i       (cur.wake),
        .mstatus_mie_i  (cur.st_bits[0]),
        .mstatus_mpie_i (cur.st_bits[1]),
        .mie_msie_i     (cur.ie_bits[0]),
        .mie_mtie_i     (cur.ie_bits[1]),
        .mie_meie_i     (cur.ie_bits[2]),
        .mip_msip_i     (cur.ip_bits[0]),
        .mip_mtip_i     (cur.ip_bits[1]),
        .mip_meip_i     (cur.ip_bits[2]),
        .mepc_i         (cur.mepc),
        .mcause_irq_i   (cur.mcause_irq),
        .mcause_ec_i    (cur.mcause_ec),
        .mtval_i        (cur.mtval),
        .ready_o        (ready),
        .rec_req_o      (rec_req),
        .rec_event_o    (rec_event),
        .rec_kind_o     (rec_kind),
        .rec_pc_o       (rec_pc),
        .rec_instr_o    (rec_instr),
        .rec_npc_o      (rec_npc),
        .rec_reg_o      (rec_reg),
        .rec_value_o    (rec_value),
        .rec_ack_i      (rec_ack)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    //----------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------
    task automatic check_event(input string sig, input trace_event_e exp,
                               input trace_event_e act);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] t=%0t %s expected %s actual %s",
                     $time, sig, exp.name(), act.name());
        end
    endtask

    task automatic check_kind(input string sig, input trace_kind_e exp, input trace_kind_e act);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] t=%0t %s expected %s actual %s",
                     $time, sig, exp.name(), act.name());
        end
    endtask

    task automatic check_word(input string sig, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h", $time, sig, exp, act);
        end
    endtask

    //----------------------------------------------------------
    // Collector on the record port
    //----------------------------------------------------------
    task automatic take_record();
        trace_rec_t exp;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("Extra record at t=%0t, nothing was expected (kind %s)",
                     $time, rec_kind.name());
        end else begin
            exp = exp_q.pop_front();
            check_event("rec_event_o", exp.ev, rec_event);
            check_kind("rec_kind_o", exp.kind, rec_kind);
            check_word("rec_pc_o", exp.pc, rec_pc);
            check_word("rec_instr_o", exp.instr, rec_instr);
            check_word("rec_npc_o", exp.npc, rec_npc);
            check_word("rec_reg_o", XLEN'(exp.reg_addr), XLEN'(rec_reg));
            check_word("rec_value_o", exp.value, rec_value);
        end
    endtask

    initial begin
        int delay;
        rec_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (rec_req && !rec_ack) begin
                delay = ack_min + ($unsigned($random(ack_seed)) % (6 - ack_min));
                repeat (delay) @(negedge clk);
                take_record();       // Fields are stable under req
                rec_ack = 1'b1;
            end else if (!rec_req && rec_ack) begin
                rec_ack = 1'b0;
            end
        end
    end

    //----------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------
    task automatic make_update(input int mode, output upd_t u);
        logic [31:0] r;
        logic [31:0] r_pc;
        int          m;
        u            = '0;
        r            = $random(seed);
        r_pc         = $random(seed);
        u.npc        = $random(seed);
        u.instr      = $random(seed);
        u.reg_data   = $random(seed);
        u.mtval      = $random(seed);
        u.mepc       = r_pc[31:1];
        u.mcause_irq = r[20];
        u.mcause_ec  = r[24:21];
        u.st_bits    = r[26:25];
        u.ie_bits    = r[29:27];
        u.ip_bits    = {r[31:30], r[3]};
        u.reg_addr   = r[8:4];
        m = mode;
        if (mode == MODE_MIX) begin
            case (r[14:13])
                2'd0:    m = MODE_REG;
                2'd1:    m = MODE_PLAIN;
                default: m = (r[15] && r[16]) ? MODE_WAKE : MODE_TRAP;   // Trap heavy
            endcase
        end
        u.update_pc = 1'b1;
        u.reg_we    = r[1];
        case (m)
            MODE_REG: begin
                u.update_pc = r[0];
                u.reg_we    = 1'b1;
                if (r[8:4] == '0) u.reg_addr = 5'd1;
            end
            MODE_PLAIN: begin
                u.reg_we = r[0];               // PC only when clear
                if (r[0]) u.reg_addr = '0;     // Writes go to x0
            end
            MODE_TRAP: begin
                u.exc  = r[9];
                u.irq  = !r[9] || r[10];      // Often both flags at once
                u.wake = r[11];
            end
            default: begin
                u.wake = 1'b1;
                if (r[12]) begin
                    u.ip_bits = ~u.ie_bits;   // Pending but all disabled
                end else begin
                    u.ie_bits[0] = 1'b1;
                    u.ip_bits[0] = 1'b1;
                end
            end
        endcase
    endtask

    // Called on a falling edge, holds the update until it is taken
    task automatic apply_update(input upd_t u);
        cur = u;
        while (!ready) begin
            stall_cnt++;
            @(negedge clk);
        end
        model_expand(u);
        @(negedge clk);
    endtask

    task automatic drive_idle();
        cur.update_pc = 1'b0;
        cur.reg_we    = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (err_cnt == err_start) begin
            test_pass++;
            $display("[DONE] %-12s passed", name);
        end else begin
            test_fail++;
            $display("[DONE] %-12s failed with %0d errors", name, err_cnt - err_start);
        end
    endtask

    task automatic run_test(input string name, input int mode, input int count,
                            input int gap_max, input bit need_stall);
        upd_t u;
        int   err_start;
        int   wait_cyc;
        int   i;
        err_start = err_cnt;
        stall_cnt = 0;
        for (i = 0; i < count; i++) begin
            make_update(mode, u);
            apply_update(u);
            if (gap_max > 0) begin
                drive_idle();
                repeat ($unsigned($random(seed)) % (gap_max + 1)) @(negedge clk);
            end
        end
        drive_idle();
        wait_cyc = 0;
        while ((exp_q.size() != 0 || rec_req || rec_ack) && wait_cyc < DRAIN_CYCLES) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("Missing records in %s, %0d expected records never arrived",
                     name, exp_q.size());
            exp_q.delete();
        end
        if (need_stall && stall_cnt == 0) begin
            err_cnt++;
            $display("ready_o never went low during %s", name);
        end
        repeat (10) @(negedge clk);           // Late extra records show up here
        finish_test(name, err_start);
    endtask

    task automatic check_reset_idle();
        int err_start;
        int i;
        err_start = err_cnt;
        check_word("ready_o", XLEN'(1'b1), XLEN'(ready));
        for (i = 0; i < 10; i++) begin
            check_word("rec_req_o", '0, XLEN'(rec_req));
            @(negedge clk);
        end
        finish_test("reset_idle", err_start);
    endtask

    //----------------------------------------------------------
    // Main sequence and watchdog
    //----------------------------------------------------------
    initial begin
        cur   = '0;
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_reset_idle();
        run_test("reg_write", MODE_REG, N_REG, 2, 1'b0);
        run_test("pc_only_x0", MODE_PLAIN, N_PLAIN, 2, 1'b0);
        run_test("trap", MODE_TRAP, N_TRAP, 3, 1'b0);
        run_test("wakeup", MODE_WAKE, N_WAKE, 2, 1'b0);
        ack_min = 3;                          // Slow collector for the burst
        run_test("burst", MODE_MIX, N_MIX, 0, 1'b1);
        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 test_pass, test_fail, err_cnt);
        if (test_fail == 0 && err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(N_TOTAL * 40 * CLK_PERIOD);
        $display("Watchdog expired at t=%0t, the run hung", $time);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== design/tracelog_top.sv ====
//----------------------------------------------------------
// Retire-trace record generator, RV32I machine mode only
// Core holds its update while ready_o is low
//----------------------------------------------------------

`timescale 1ns/1ps

module tracelog_top
    import tracelog_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Core retire side
    input  logic                  update_pc_i,
    input  logic [XLEN-1:0]       npc_i,
    input  logic [ILEN-1:0]       instr_i,
    input  logic                  reg_we_i,
    input  logic [REG_AWIDTH-1:0] reg_addr_i,
    input  logic [XLEN-1:0]       reg_data_i,
    input  logic                  e_exc_i,
    input  logic                  e_irq_i,
    input  logic                  e_wake_i,
    // CSR bits
    input  logic                  mstatus_mie_i,
    input  logic                  mstatus_mpie_i,
    input  logic                  mie_msie_i,
    input  logic                  mie_mtie_i,
    input  logic                  mie_meie_i,
    input  logic                  mip_msip_i,
    input  logic                  mip_mtip_i,
    input  logic                  mip_meip_i,
    input  logic [XLEN-1:1]       mepc_i,
    input  logic                  mcause_irq_i,
    input  logic [EC_WIDTH-1:0]   mcause_ec_i,
    input  logic [XLEN-1:0]       mtval_i,
    output logic                  ready_o,
    // Record port, four-phase req/ack
    output logic                  rec_req_o,
    output trace_event_e          rec_event_o,
    output trace_kind_e           rec_kind_o,
    output logic [XLEN-1:0]       rec_pc_o,
    output logic [ILEN-1:0]       rec_instr_o,
    output logic [XLEN-1:0]       rec_npc_o,
    output logic [REG_AWIDTH-1:0] rec_reg_o,
    output logic [XLEN-1:0]       rec_value_o,
    input  logic                  rec_ack_i
);

    retire_if u_retire_if ();
    record_if u_record_if ();

    trace_capture u_trace_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .update_pc_i    (update_pc_i),
        .npc_i          (npc_i),
        .instr_i        (instr_i),
        .reg_we_i       (reg_we_i),
        .reg_addr_i     (reg_addr_i),
        .reg_data_i     (reg_data_i),
        .e_exc_i        (e_exc_i),
        .e_irq_i        (e_irq_i),
        .e_wake_i       (e_wake_i),
        .mstatus_mie_i  (mstatus_mie_i),
        .mstatus_mpie_i (mstatus_mpie_i),
        .mie_msie_i     (mie_msie_i),
        .mie_mtie_i     (mie_mtie_i),
        .mie_meie_i     (mie_meie_i),
        .mip_msip_i     (mip_msip_i),
        .mip_mtip_i     (mip_mtip_i),
        .mip_meip_i     (mip_meip_i),
        .mepc_i         (mepc_i),
        .mcause_irq_i   (mcause_irq_i),
        .mcause_ec_i    (mcause_ec_i),
        .mtval_i        (mtval_i),
        .ready_o        (ready_o),
        .retire_o       (u_retire_if.src)
    );

    trace_record_builder u_trace_record_builder (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire_i (u_retire_if.snk),
        .record_o (u_record_if.src)
    );

    trace_out_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_trace_out_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .record_i    (u_record_if.snk),
        .rec_req_o   (rec_req_o),
        .rec_event_o (rec_event_o),
        .rec_kind_o  (rec_kind_o),
        .rec_pc_o    (rec_pc_o),
        .rec_instr_o (rec_instr_o),
        .rec_npc_o   (rec_npc_o),
        .rec_reg_o   (rec_reg_o),
        .rec_value_o (rec_value_o),
        .rec_ack_i   (rec_ack_i)
    );

endmodule

// ==== design/trace_out_port.sv ====
//----------------------------------------------------------
// Record queue and four-phase req/ack sender
// FIFO_DEPTH must be a power of two, at least 2
//----------------------------------------------------------

`timescale 1ns/1ps

module trace_out_port
    import tracelog_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    record_if.snk                 record_i,
    output logic                  rec_req_o,
    output trace_event_e          rec_event_o,
    output trace_kind_e           rec_kind_o,
    output logic [XLEN-1:0]       rec_pc_o,
    output logic [ILEN-1:0]       rec_instr_o,
    output logic [XLEN-1:0]       rec_npc_o,
    output logic [REG_AWIDTH-1:0] rec_reg_o,
    output logic [XLEN-1:0]       rec_value_o,
    input  logic                  rec_ack_i
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } snd_state_e;

    snd_state_e     state_q;
    trace_rec_t     mem_q [0:FIFO_DEPTH-1];
    logic [PTR_W:0] wr_ptr_q;    // Extra bit tells full from empty
    logic [PTR_W:0] rd_ptr_q;
    logic           empty;
    logic           full;
    logic           push;
    logic           pop;
    trace_rec_t     head;

    //----------------------------------------------------------
    // Queue
    //----------------------------------------------------------
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W])
                && (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
    assign record_i.ready = !full;
    assign push = record_i.valid && !full;
    assign pop  = (state_q == REQ) && rec_ack_i;    // Ack seen, head is done
    assign head = mem_q[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (push) mem_q[wr_ptr_q[PTR_W-1:0]] <= record_i.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    //----------------------------------------------------------
    // Four-phase sender
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:         if (!empty)    state_q <= REQ;
                REQ:          if (rec_ack_i) state_q <= WAIT_ACK_LOW;
                WAIT_ACK_LOW: if (!rec_ack_i) state_q <= IDLE;
                default:      state_q <= IDLE;
            endcase
        end
    end

    assign rec_req_o   = (state_q == REQ);
    // Head stays put until popped, so fields are stable under req
    assign rec_event_o = head.ev;
    assign rec_kind_o  = head.kind;
    assign rec_pc_o    = head.pc;
    assign rec_instr_o = head.instr;
    assign rec_npc_o   = head.npc;
    assign rec_reg_o   = head.reg_addr;
    assign rec_value_o = head.value;

endmodule

// ==== design/trace_record_builder.sv ====
//----------------------------------------------------------
// Expands one captured retire into 1, 2 or 4 records
// A new retire is taken only after the last record leaves
//----------------------------------------------------------

`timescale 1ns/1ps

module trace_record_builder
    import tracelog_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    retire_if.snk retire_i,
    record_if.src record_o
);

    typedef enum logic {
        IDLE,
        EMIT
    } bld_state_e;

    bld_state_e      state_q;
    logic [1:0]      step_q;      // Index into the record list
    logic [1:0]      last_step;
    retire_t         cur_q;
    logic            wake_pend;
    logic            reg_rec;
    trace_kind_e     kind;
    logic [XLEN-1:0] value;

    assign retire_i.ready = (state_q == IDLE);

    // Any enabled interrupt pending
    assign wake_pend = |(cur_q.csr.mip & cur_q.csr.mie);
    // x0 writes are not reported
    assign reg_rec   = cur_q.reg_we && (cur_q.reg_addr != '0);

    //----------------------------------------------------------
    // Record list for the event
    //----------------------------------------------------------
    always_comb begin
        kind      = REC_NONE;
        last_step = 2'd0;
        case (cur_q.ev)
            EV_EXC, EV_IRQ: begin
                last_step = 2'd3;
                case (step_q)
                    2'd0:    kind = REC_MSTATUS;
                    2'd1:    kind = REC_MEPC;
                    2'd2:    kind = REC_MCAUSE;
                    default: kind = REC_MTVAL;
                endcase
            end
            EV_WAKE: begin
                if (wake_pend) begin
                    last_step = 2'd1;
                    kind      = (step_q == 2'd0) ? REC_MIP : REC_MIE;
                end
            end
            default: begin
                if (reg_rec) kind = REC_REG;
            end
        endcase
    end

    always_comb begin
        case (kind)
            REC_REG:     value = cur_q.reg_data;
            REC_MSTATUS: value = cur_q.csr.mstatus;
            REC_MEPC:    value = cur_q.csr.mepc;
            REC_MCAUSE:  value = cur_q.csr.mcause;
            REC_MTVAL:   value = cur_q.csr.mtval;
            REC_MIP:     value = cur_q.csr.mip;
            REC_MIE:     value = cur_q.csr.mie;
            default:     value = '0;     // Empty record
        endcase
    end

    //----------------------------------------------------------
    // Record output
    //----------------------------------------------------------
    assign record_o.valid         = (state_q == EMIT);
    assign record_o.data.ev       = cur_q.ev;
    assign record_o.data.kind     = kind;
    assign record_o.data.pc       = cur_q.pc;
    assign record_o.data.instr    = cur_q.instr;
    assign record_o.data.npc      = cur_q.npc;
    assign record_o.data.reg_addr = (kind == REC_REG) ? cur_q.reg_addr : '0;
    assign record_o.data.value    = value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            step_q  <= 2'd0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (retire_i.valid) begin
                        state_q <= EMIT;
                        step_q  <= 2'd0;
                    end
                end
                EMIT: begin
                    if (record_o.ready) begin
                        if (step_q == last_step) state_q <= IDLE;
                        else                     step_q  <= step_q + 2'd1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Hold the retire while its records go out
    always_ff @(posedge clk) begin
        if (retire_i.valid && retire_i.ready) cur_q <= retire_i.data;
    end

endmodule

// ==== design/trace_capture.sv ====
//----------------------------------------------------------
// Registers core retire data and classifies the event
// Core must hold its update while ready_o is low
//----------------------------------------------------------

`timescale 1ns/1ps

module trace_capture
    import tracelog_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  update_pc_i,
    input  logic [XLEN-1:0]       npc_i,
    input  logic [ILEN-1:0]       instr_i,
    input  logic                  reg_we_i,
    input  logic [REG_AWIDTH-1:0] reg_addr_i,
    input  logic [XLEN-1:0]       reg_data_i,
    input  logic                  e_exc_i,
    input  logic                  e_irq_i,
    input  logic                  e_wake_i,
    input  logic                  mstatus_mie_i,
    input  logic                  mstatus_mpie_i,
    input  logic                  mie_msie_i,
    input  logic                  mie_mtie_i,
    input  logic                  mie_meie_i,
    input  logic                  mip_msip_i,
    input  logic                  mip_mtip_i,
    input  logic                  mip_meip_i,
    input  logic [XLEN-1:1]       mepc_i,
    input  logic                  mcause_irq_i,
    input  logic [EC_WIDTH-1:0]   mcause_ec_i,
    input  logic [XLEN-1:0]       mtval_i,
    output logic                  ready_o,
    retire_if.src                 retire_o
);

    logic            accept;
    logic            valid_q;
    logic [XLEN-1:0] npc_prev_q;   // Start of the PC chain
    trace_event_e    ev;
    csr_snap_t       csr_now;

    // Back-pressure reaches the core while an item waits
    assign ready_o = !valid_q || retire_o.ready;
    assign accept  = (update_pc_i || reg_we_i) && ready_o;
    assign retire_o.valid = valid_q;

    // Exception beats interrupt beats wakeup
    always_comb begin
        if (e_exc_i)       ev = EV_EXC;
        else if (e_irq_i)  ev = EV_IRQ;
        else if (e_wake_i) ev = EV_WAKE;
        else               ev = EV_NONE;
    end

    always_comb begin
        csr_now = '0;
        csr_now.mstatus[MSTATUS_MIE_OFF]  = mstatus_mie_i;
        csr_now.mstatus[MSTATUS_MPIE_OFF] = mstatus_mpie_i;
        csr_now.mstatus[MSTATUS_MPP_OFF+1:MSTATUS_MPP_OFF] = MSTATUS_MPP_M;
        csr_now.mie[IRQ_MS_OFF] = mie_msie_i;
        csr_now.mie[IRQ_MT_OFF] = mie_mtie_i;
        csr_now.mie[IRQ_ME_OFF] = mie_meie_i;
        csr_now.mip[IRQ_MS_OFF] = mip_msip_i;
        csr_now.mip[IRQ_MT_OFF] = mip_mtip_i;
        csr_now.mip[IRQ_ME_OFF] = mip_meip_i;
        csr_now.mepc   = {mepc_i, 1'b0};         // IALIGN 32, low bit rebuilt
        csr_now.mcause[XLEN-1]       = mcause_irq_i;
        csr_now.mcause[EC_WIDTH-1:0] = mcause_ec_i;
        csr_now.mtval  = mtval_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            npc_prev_q <= '0;
        end else if (accept) begin
            valid_q    <= 1'b1;
            npc_prev_q <= npc_i;
        end else if (retire_o.ready) begin
            valid_q    <= 1'b0;    // Item taken, nothing new
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept) begin
            retire_o.data.ev       <= ev;
            retire_o.data.pc       <= npc_prev_q;
            retire_o.data.instr    <= instr_i;
            retire_o.data.npc      <= npc_i;
            retire_o.data.reg_we   <= reg_we_i;
            retire_o.data.reg_addr <= reg_addr_i;
            retire_o.data.reg_data <= reg_data_i;
            retire_o.data.csr      <= csr_now;
        end
    end

endmodule

// ==== design/trace_if.sv ====
//----------------------------------------------------------
// Valid/ready links between the trace stages
// Data must stay stable while valid is high
//----------------------------------------------------------

`timescale 1ns/1ps

// Captured retire, capture stage to record builder
interface retire_if
    import tracelog_pkg::*;
();
    logic    valid;
    logic    ready;
    retire_t data;

    modport src (
        output valid,
        output data,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        output ready
    );
endinterface

// Built record, record builder to output port
interface record_if
    import tracelog_pkg::*;
();
    logic       valid;
    logic       ready;
    trace_rec_t data;

    modport src (output valid, output data, input ready);
    modport snk (input valid, input data, output ready);
endinterface

// ==== design/tracelog_pkg.sv ====
//----------------------------------------------------------
// Shared widths, CSR bit offsets and record types
// RV32I only, so machine mode is the sole privilege level
//----------------------------------------------------------

package tracelog_pkg;

    //----------------------------------------------------------
    // Widths
    //----------------------------------------------------------
    parameter int XLEN       = 32;
    parameter int ILEN       = 32;
    parameter int REG_AWIDTH = 5;
    parameter int EC_WIDTH   = 4;

    //----------------------------------------------------------
    // CSR bit offsets
    //----------------------------------------------------------
    parameter int MSTATUS_MIE_OFF  = 3;
    parameter int MSTATUS_MPIE_OFF = 7;
    parameter int MSTATUS_MPP_OFF  = 11;       // Two bits, 12:11
    parameter logic [1:0] MSTATUS_MPP_M = 2'b11; // Machine mode

    // Same positions in mie and mip
    parameter int IRQ_MS_OFF = 3;    // MSIE / MSIP
    parameter int IRQ_MT_OFF = 7;    // MTIE / MTIP
    parameter int IRQ_ME_OFF = 11;   // MEIE / MEIP

    //----------------------------------------------------------
    // Enums and structs
    //----------------------------------------------------------
    typedef enum logic [1:0] {
        EV_NONE,
        EV_EXC,
        EV_IRQ,
        EV_WAKE
    } trace_event_e;

    typedef enum logic [2:0] {
        REC_NONE,
        REC_REG,
        REC_MSTATUS,
        REC_MEPC,
        REC_MCAUSE,
        REC_MTVAL,
        REC_MIP,
        REC_MIE
    } trace_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] mstatus;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mip;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } csr_snap_t;

    // One captured retire or register write
    typedef struct packed {
        trace_event_e          ev;
        logic [XLEN-1:0]       pc;
        logic [ILEN-1:0]       instr;
        logic [XLEN-1:0]       npc;
        logic                  reg_we;
        logic [REG_AWIDTH-1:0] reg_addr;
        logic [XLEN-1:0]       reg_data;
        csr_snap_t             csr;
    } retire_t;

    // One output trace record
    typedef struct packed {
        trace_event_e          ev;
        trace_kind_e           kind;
        logic [XLEN-1:0]       pc;
        logic [ILEN-1:0]       instr;
        logic [XLEN-1:0]       npc;
        logic [REG_AWIDTH-1:0] reg_addr;
        logic [XLEN-1:0]       value;
    } trace_rec_t;

endpackage
